//--- logic/tenyr_bus_pkg.sv
`default_nettype none

package tenyr_bus_pkg;

    typedef logic [31:0] addr_t; // word address that selects one data word
    typedef logic [31:0] data_t;
    typedef logic [3:0]  sel_t;  // one select bit per byte lane with bit 0 on bits 7:0

    // ==================================================================
    // device address map
    // ==================================================================

    // a window matches when (adr & MASK) == BASE
    localparam addr_t GPIO_BASE = 32'h0000_0200;
    localparam addr_t GPIO_MASK = 32'hffff_fffc; // four registers
    localparam addr_t SEG7_BASE = 32'h0000_0100;
    localparam addr_t SEG7_MASK = 32'hffff_fffe; // two registers

    // the processor starts fetching here after reset
    localparam addr_t RAM_BASE = 32'h0000_1000;

    // read value of any address that no device claims
    localparam data_t DEFAULT_RDATA = 32'hffff_ffff;

    // ==================================================================
    // helpers
    // ==================================================================

    // replaces the byte lanes of old_w whose select bit is set
    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w,
                                          input sel_t sel);
        data_t res;
        res = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

`default_nettype wire

//--- logic/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    import tenyr_bus_pkg::*;

    addr_t adr;   // word address of the access
    data_t dat_w; // master to slave
    data_t dat_r; // slave to master and valid with ack on a read
    logic  we;
    sel_t  sel;
    logic  stb;
    logic  cyc;
    logic  ack;

    // the decoder sits on this side
    modport master (
        output adr,
        output dat_w,
        output we,
        output sel,
        output stb,
        output cyc,
        input  dat_r,
        input  ack
    );

    modport slave (
        input  adr,
        input  dat_w,
        input  we,
        input  sel,
        input  stb,
        input  cyc,
        output dat_r,
        output ack
    );

endinterface

`default_nettype wire

//--- logic/wb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module wb_decode #(
    parameter int RAM_ABITS = 10
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  tenyr_bus_pkg::addr_t  wb_adr_i,
    input  tenyr_bus_pkg::data_t  wb_dat_i,
    output tenyr_bus_pkg::data_t  wb_dat_o,
    input  logic                  wb_we_i,
    input  tenyr_bus_pkg::sel_t   wb_sel_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_cyc_i,
    output logic                  wb_ack_o,
    wb_if.master                  ram_bus,
    wb_if.master                  gpio_bus,
    wb_if.master                  seg_bus
);
    import tenyr_bus_pkg::*;

    typedef enum logic [1:0] {
        SLV_GPIO,
        SLV_SEG7,
        SLV_RAM,
        SLV_DFLT
    } slave_e;

    localparam addr_t RAM_WORDS = addr_t'(1) << RAM_ABITS;

    addr_t  ram_off;  // address relative to the start of RAM
    slave_e hit_sel;  // slave matched by the current address
    slave_e held_sel;
    slave_e cur_sel;
    logic   busy_q;   // a request is open and still waiting for its ack
    logic   req;

    assign req     = wb_stb_i & wb_cyc_i;
    assign ram_off = wb_adr_i - RAM_BASE;

    // ==================================================================
    // window match, in priority order
    // ==================================================================

    always_comb begin
        if ((wb_adr_i & GPIO_MASK) == GPIO_BASE) begin
            hit_sel = SLV_GPIO;
        end else if ((wb_adr_i & SEG7_MASK) == SEG7_BASE) begin
            hit_sel = SLV_SEG7;
        end else if (ram_off < RAM_WORDS) begin
            hit_sel = SLV_RAM;
        end else begin
            hit_sel = SLV_DFLT;
        end
    end

    // the slave picked in the first cycle keeps the bus until it acks
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= req & ~wb_ack_o;
        end
    end

    always_ff @(posedge clk) begin
        held_sel <= cur_sel;
    end

    assign cur_sel = busy_q ? held_sel : hit_sel;

    // ==================================================================
    // request fan-out
    // ==================================================================

    assign ram_bus.adr   = ram_off; // RAM sees word offsets from its base
    assign ram_bus.dat_w = wb_dat_i;
    assign ram_bus.we    = wb_we_i;
    assign ram_bus.sel   = wb_sel_i;
    assign ram_bus.stb   = wb_stb_i & (cur_sel == SLV_RAM);
    assign ram_bus.cyc   = wb_cyc_i & (cur_sel == SLV_RAM);

    assign gpio_bus.adr   = wb_adr_i;
    assign gpio_bus.dat_w = wb_dat_i;
    assign gpio_bus.we    = wb_we_i;
    assign gpio_bus.sel   = wb_sel_i;
    assign gpio_bus.stb   = wb_stb_i & (cur_sel == SLV_GPIO);
    assign gpio_bus.cyc   = wb_cyc_i & (cur_sel == SLV_GPIO);

    assign seg_bus.adr   = wb_adr_i;
    assign seg_bus.dat_w = wb_dat_i;
    assign seg_bus.we    = wb_we_i;
    assign seg_bus.sel   = wb_sel_i;
    assign seg_bus.stb   = wb_stb_i & (cur_sel == SLV_SEG7);
    assign seg_bus.cyc   = wb_cyc_i & (cur_sel == SLV_SEG7);

    // the default slave answers at once and drops writes
    always_comb begin
        case (cur_sel)
            SLV_GPIO: begin
                wb_ack_o = gpio_bus.ack;
                wb_dat_o = gpio_bus.dat_r;
            end
            SLV_SEG7: begin
                wb_ack_o = seg_bus.ack;
                wb_dat_o = seg_bus.dat_r;
            end
            SLV_RAM: begin
                wb_ack_o = ram_bus.ack;
                wb_dat_o = ram_bus.dat_r;
            end
            default: begin
                wb_ack_o = req;
                wb_dat_o = DEFAULT_RDATA;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/bus_ram.sv
`timescale 1ns/1ps
`default_nettype none

module bus_ram #(
    parameter int RAM_ABITS = 10
) (
    input logic  clk,
    wb_if.slave  bus
);
    import tenyr_bus_pkg::*;

    localparam int DEPTH = 1 << RAM_ABITS;

    // ==================================================================
    // storage
    // ==================================================================

    data_t                mem [DEPTH]; // contents are undefined after reset
    data_t                rdata_q;
    logic                 ack_q;
    logic                 req;
    logic                 accept;
    logic [RAM_ABITS-1:0] idx;

    assign req = bus.stb & bus.cyc;
    assign idx = bus.adr[RAM_ABITS-1:0];

    // ack_q also marks the cycle after an answered request, so a strobe
    // still high in that cycle is not served a second time
    assign accept = req & ~ack_q;

    always_ff @(posedge clk) begin
        if (accept && bus.we) begin
            mem[idx] <= merge_bytes(mem[idx], bus.dat_w, bus.sel);
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx]; // data from before a write in the same cycle
        end
    end

    // ack is high for exactly one cycle per accepted request
    always_ff @(posedge clk) begin
        ack_q <= accept;
    end

    // ==================================================================
    // bus response
    // ==================================================================

    assign bus.ack   = ack_q;
    assign bus.dat_r = rdata_q;

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port #(
    parameter int GPIO_COUNT = 24
) (
    input  logic                  clk,
    input  logic                  reset_i,
    wb_if.slave                   bus,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o
);
    import tenyr_bus_pkg::*;

    logic [GPIO_COUNT-1:0] out_q;   // values driven on the pins
    logic [GPIO_COUNT-1:0] dir_q;   // a one drives the pin
    logic [GPIO_COUNT-1:0] sync1_q;
    logic [GPIO_COUNT-1:0] sync2_q;
    logic                  req;
    data_t                 out_new;
    data_t                 dir_new;

    assign req = bus.stb & bus.cyc;

    // ==================================================================
    // register writes
    // ==================================================================

    assign out_new = merge_bytes(data_t'(out_q), bus.dat_w, bus.sel);
    assign dir_new = merge_bytes(data_t'(dir_q), bus.dat_w, bus.sel);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_q <= '0;
            dir_q <= '0; // every pin starts as an input
        end else if (req && bus.we) begin
            case (bus.adr[1:0])
                2'd0:    out_q <= out_new[GPIO_COUNT-1:0];
                2'd1:    dir_q <= dir_new[GPIO_COUNT-1:0];
                default: ; // input and spare words ignore writes
            endcase
        end
    end

    // pins come from outside this clock domain
    always_ff @(posedge clk) begin
        sync1_q <= gpio_i;
        sync2_q <= sync1_q;
    end

    // ==================================================================
    // bus response
    // ==================================================================

    assign bus.ack = req; // same-cycle answer

    always_comb begin
        case (bus.adr[1:0])
            2'd0:    bus.dat_r = data_t'(out_q);
            2'd1:    bus.dat_r = data_t'(dir_q);
            2'd2:    bus.dat_r = data_t'(sync2_q);
            default: bus.dat_r = '0;
        endcase
    end

    assign gpio_o    = out_q;
    assign gpio_oe_o = dir_q;

endmodule

`default_nettype wire

//--- logic/seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan #(
    parameter int SCAN_DIV = 4
) (
    input  logic       clk,
    input  logic       reset_i,
    wb_if.slave        bus,
    output logic [7:0] seg_o,
    output logic [3:0] an_o
);
    import tenyr_bus_pkg::*;

    localparam int                PRE_W    = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(SCAN_DIV - 1);

    logic [15:0]      digits_q; // digit 0 lives in bits 3:0
    logic [3:0]       dp_q;     // one decimal point per digit
    logic [PRE_W-1:0] pre_q;
    logic [1:0]       digit_q;  // digit currently lit
    logic             req;
    data_t            digits_new;
    data_t            dp_new;

    assign req        = bus.stb & bus.cyc;
    assign digits_new = merge_bytes(data_t'(digits_q), bus.dat_w, bus.sel);
    assign dp_new     = merge_bytes(data_t'(dp_q), bus.dat_w, bus.sel);

    // ==================================================================
    // bus registers
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            digits_q <= '0;
            dp_q     <= '0;
        end else if (req && bus.we) begin
            if (bus.adr[0]) dp_q <= dp_new[3:0];
            else            digits_q <= digits_new[15:0];
        end
    end

    assign bus.ack   = req;
    assign bus.dat_r = bus.adr[0] ? data_t'(dp_q) : data_t'(digits_q);

    // ==================================================================
    // digit scanner
    // ==================================================================

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pre_q   <= '0;
            digit_q <= '0;
        end else if (pre_q == PRE_LAST) begin
            pre_q   <= '0;
            digit_q <= digit_q + 2'd1; // wraps from 3 back to 0
        end else begin
            pre_q <= pre_q + 1'b1;
        end
    end

    // hex glyphs for segments g down to a, driven active low
    function automatic logic [6:0] hex_seg(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0: lit = 7'h3f;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5b;
            4'h3: lit = 7'h4f;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6d;
            4'h6: lit = 7'h7d;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7f;
            4'h9: lit = 7'h6f;
            4'ha: lit = 7'h77;
            4'hb: lit = 7'h7c;
            4'hc: lit = 7'h39;
            4'hd: lit = 7'h5e;
            4'he: lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    assign an_o  = ~(4'b0001 << digit_q);
    assign seg_o = {~dp_q[digit_q], hex_seg(digits_q[4*digit_q +: 4])};

endmodule

`default_nettype wire

//--- logic/tenyr_devices.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_devices #(
    parameter int RAM_ABITS  = 10,
    parameter int GPIO_COUNT = 24,
    parameter int SCAN_DIV   = 4
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  tenyr_bus_pkg::addr_t  wb_adr_i,
    input  tenyr_bus_pkg::data_t  wb_dat_i,
    output tenyr_bus_pkg::data_t  wb_dat_o,
    input  logic                  wb_we_i,
    input  tenyr_bus_pkg::sel_t   wb_sel_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_cyc_i,
    output logic                  wb_ack_o,
    input  logic [GPIO_COUNT-1:0] gpio_i,
    output logic [GPIO_COUNT-1:0] gpio_o,
    output logic [GPIO_COUNT-1:0] gpio_oe_o,
    output logic [7:0]            seg_o,
    output logic [3:0]            an_o
);

    wb_if ram_bus ();
    wb_if gpio_bus ();
    wb_if seg_bus ();

    // ==================================================================
    // bus fabric
    // ==================================================================

    wb_decode #(
        .RAM_ABITS (RAM_ABITS)
    ) decode (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_we_i  (wb_we_i),
        .wb_sel_i (wb_sel_i),
        .wb_stb_i (wb_stb_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_ack_o (wb_ack_o),
        .ram_bus  (ram_bus.master),
        .gpio_bus (gpio_bus.master),
        .seg_bus  (seg_bus.master)
    );

    // ==================================================================
    // devices
    // ==================================================================

    bus_ram #(
        .RAM_ABITS (RAM_ABITS)
    ) ram (
        .clk (clk),
        .bus (ram_bus.slave)
    );

    gpio_port #(
        .GPIO_COUNT (GPIO_COUNT)
    ) gpio (
        .clk       (clk),
        .reset_i   (reset_i),
        .bus       (gpio_bus.slave),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o)
    );

    seg7_scan #(
        .SCAN_DIV (SCAN_DIV)
    ) seg7 (
        .clk     (clk),
        .reset_i (reset_i),
        .bus     (seg_bus.slave),
        .seg_o   (seg_o),
        .an_o    (an_o)
    );

endmodule

`default_nettype wire

//--- sim/tenyr_devices_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module tenyr_devices_asserts (
    input logic       clk,
    input logic       reset_i,
    input logic       stb_i,
    input logic       cyc_i,
    input logic       ack_i,
    input logic       ram_ack_i,
    input logic [3:0] an_i
);

    // ==================================================================
    // bus handshake
    // ==================================================================

    // every ack answers an open request
    ack_has_request: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> (stb_i && cyc_i))
        else $error("ack raised without stb and cyc");

    ram_ack_single: assert property (@(posedge clk) disable iff (reset_i)
        ram_ack_i |=> !ram_ack_i) // one ack per RAM request
        else $error("RAM ack high on two cycles in a row");

    // ==================================================================
    // display
    // ==================================================================

    // the lit digit either stays or moves on to the next one in scan order
    one_digit_lit: assert property (@(posedge clk) disable iff (reset_i)
        $onehot(~an_i) &&
        ((an_i == $past(an_i)) || (an_i == {$past(an_i[2:0]), $past(an_i[3])})))
        else $error("an_o does not enable exactly one digit in scan order");

endmodule

// checks the top-level handshake together with the RAM ack and the digit enables
bind tenyr_devices tenyr_devices_asserts asserts0 (
    .clk       (clk),
    .reset_i   (reset_i),
    .stb_i     (wb_stb_i),
    .cyc_i     (wb_cyc_i),
    .ack_i     (wb_ack_o),
    .ram_ack_i (ram_bus.ack),
    .an_i      (an_o)
);

`default_nettype wire

//--- sim/tb_tenyr_devices.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tenyr_devices;
    import tenyr_bus_pkg::*;

    localparam int RAM_ABITS  = 10;
    localparam int GPIO_COUNT = 24;
    localparam int SCAN_DIV   = 4;
    localparam int RAM_WORDS  = 1 << RAM_ABITS;
    localparam int N_RAM      = 200;
    localparam int N_GPIO     = 60;
    localparam int N_SEG      = 8;
    localparam int N_DFLT     = 40;
    // RAM is counted twice because the final pass reads every written word again
    localparam int N_TXN       = 2 + 2 * N_RAM + 4 * N_GPIO + 4 * N_SEG + 2 * N_DFLT + 6;
    localparam int CYCLE_LIMIT = 20 * N_TXN + 500;
    localparam data_t GPIO_VALID = (data_t'(1) << GPIO_COUNT) - data_t'(1);

    // lit segments g down to a for each hex digit
    localparam logic [6:0] HEX_LIT [16] = '{
        7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d, 7'h07,
        7'h7f, 7'h6f, 7'h77, 7'h7c, 7'h39, 7'h5e, 7'h79, 7'h71
    };

    logic                  clk = 1'b0;
    logic                  reset_i;
    addr_t                 wb_adr_i;
    data_t                 wb_dat_i;
    data_t                 wb_dat_o;
    logic                  wb_we_i;
    sel_t                  wb_sel_i;
    logic                  wb_stb_i;
    logic                  wb_cyc_i;
    logic                  wb_ack_o;
    logic [GPIO_COUNT-1:0] gpio_i;
    logic [GPIO_COUNT-1:0] gpio_o;
    logic [GPIO_COUNT-1:0] gpio_oe_o;
    logic [7:0]            seg_o;
    logic [3:0]            an_o;

    // reference model state
    data_t ram_model [RAM_WORDS];
    bit    ram_valid [RAM_WORDS]; // words the model knows completely
    int    written_q [$];
    data_t gpio_out_model;
    data_t gpio_dir_model;
    data_t seg_digits_model;
    data_t seg_dp_model;
    int    cycle_cnt = 0;

    tenyr_devices #(
        .RAM_ABITS  (RAM_ABITS),
        .GPIO_COUNT (GPIO_COUNT),
        .SCAN_DIV   (SCAN_DIV)
    ) dut0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_dat_o  (wb_dat_o),
        .wb_we_i   (wb_we_i),
        .wb_sel_i  (wb_sel_i),
        .wb_stb_i  (wb_stb_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_ack_o  (wb_ack_o),
        .gpio_i    (gpio_i),
        .gpio_o    (gpio_o),
        .gpio_oe_o (gpio_oe_o),
        .seg_o     (seg_o),
        .an_o      (an_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            abort_run("timeout, the run went past its cycle limit");
        end
    end

    // ==================================================================
    // checking helpers
    // ==================================================================

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED time %0t signal %s actual 0x%08h expected 0x%08h",
                     $time, name, actual, expected);
            abort_run("value mismatch");
        end
    endtask

    // byte lanes whose select bit is set take the new value
    function automatic data_t lane_merge(input data_t old_w, input data_t new_w, input sel_t sel);
        data_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic addr_t pick_unmapped();
        addr_t adr;
        do begin
            adr = $urandom_range(1) ? $urandom : $urandom_range(32'h1fff); // low half hits edges
        end while (((adr & GPIO_MASK) == GPIO_BASE) || ((adr & SEG7_MASK) == SEG7_BASE) ||
                   ((adr - RAM_BASE) < addr_t'(RAM_WORDS)));
        return adr;
    endfunction

    // ==================================================================
    // bus master
    // ==================================================================

    task automatic bus_cycle(input logic we, input addr_t adr, input data_t dat, input sel_t sel,
                             output data_t rdata, output int cycles);
        cycles = 0;
        @(posedge clk);
        wb_adr_i <= adr;
        wb_dat_i <= dat;
        wb_we_i  <= we;
        wb_sel_i <= sel;
        wb_stb_i <= 1'b1;
        wb_cyc_i <= 1'b1;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack_o);
        rdata = wb_dat_o;
        @(posedge clk); // the slave sees its ack taken on this edge
        wb_stb_i <= 1'b0;
        wb_cyc_i <= 1'b0;
        wb_we_i  <= 1'b0;
    endtask

    task automatic bus_write(input addr_t adr, input data_t dat, input sel_t sel, input int lat);
        data_t rd;
        int    cycles;
        bus_cycle(1'b1, adr, dat, sel, rd, cycles);
        check_value("wb_ack_o latency", cycles, lat);
    endtask

    task automatic bus_read(input addr_t adr, output data_t rd, input int lat);
        int cycles;
        bus_cycle(1'b0, adr, '0, 4'hf, rd, cycles);
        check_value("wb_ack_o latency", cycles, lat);
    endtask

    // ==================================================================
    // tests
    // ==================================================================

    task automatic check_reset_state();
        data_t rd;
        @(negedge clk);
        check_value("gpio_o", data_t'(gpio_o), '0);
        check_value("gpio_oe_o", data_t'(gpio_oe_o), '0);
        check_value("an_o", data_t'(an_o), 32'he);
        bus_read(SEG7_BASE, rd, 1);
        check_value("wb_dat_o", rd, '0);
        bus_read(SEG7_BASE + 32'd1, rd, 1);
        check_value("wb_dat_o", rd, '0);
    endtask

    task automatic run_ram_test();
        int    idx;
        sel_t  sel;
        data_t dat;
        data_t rd;
        for (int n = 0; n < N_RAM; n++) begin
            if (written_q.size() == 0 || $urandom_range(1) == 0) begin
                idx = int'($urandom_range(RAM_WORDS - 1));
                dat = $urandom;
                // a first write covers the whole word so no lane stays unknown
                sel = ram_valid[idx] ? sel_t'($urandom_range(15)) : 4'hf;
                bus_write(RAM_BASE + addr_t'(idx), dat, sel, 2);
                if (!ram_valid[idx]) written_q.push_back(idx);
                ram_model[idx] = lane_merge(ram_model[idx], dat, sel);
                ram_valid[idx] = 1'b1;
            end else begin
                idx = written_q[$urandom_range(written_q.size() - 1)];
                bus_read(RAM_BASE + addr_t'(idx), rd, 2);
                check_value("wb_dat_o", rd, ram_model[idx]);
            end
        end
    endtask

    task automatic run_gpio_test();
        int    reg_sel;
        data_t dat;
        data_t pins;
        data_t rd;
        sel_t  sel;
        for (int n = 0; n < N_GPIO; n++) begin
            reg_sel = int'($urandom_range(1));
            dat     = $urandom;
            sel     = sel_t'($urandom_range(15));
            bus_write(GPIO_BASE + addr_t'(reg_sel), dat, sel, 1);
            if (reg_sel == 0) gpio_out_model = lane_merge(gpio_out_model, dat, sel) & GPIO_VALID;
            else              gpio_dir_model = lane_merge(gpio_dir_model, dat, sel) & GPIO_VALID;
            @(negedge clk);
            check_value("gpio_o", data_t'(gpio_o), gpio_out_model);
            check_value("gpio_oe_o", data_t'(gpio_oe_o), gpio_dir_model);
            bus_read(GPIO_BASE + addr_t'(reg_sel), rd, 1);
            check_value("wb_dat_o", rd, (reg_sel == 0) ? gpio_out_model : gpio_dir_model);

            pins = $urandom;
            @(posedge clk);
            gpio_i <= pins[GPIO_COUNT-1:0];
            repeat (2) @(posedge clk); // two synchronizer stages
            bus_read(GPIO_BASE + 32'd2, rd, 1);
            check_value("wb_dat_o", rd, pins & GPIO_VALID);
            bus_read(GPIO_BASE + 32'd3, rd, 1);
            check_value("wb_dat_o", rd, '0);
        end
    endtask

    // watches two full scan rounds and checks each digit as it is lit
    task automatic check_scan();
        int         cur;
        int         prev;
        logic [3:0] seen;
        logic [3:0] nib;
        logic [7:0] exp_seg;
        prev = -1;
        seen = '0;
        for (int c = 0; c < 2 * 4 * SCAN_DIV; c++) begin
            @(negedge clk);
            cur = -1;
            for (int d = 0; d < 4; d++) begin
                if (an_o[d] == 1'b0 && $countones(an_o) == 3) cur = d;
            end
            if (cur < 0) abort_run("an_o does not enable exactly one digit");
            if (prev >= 0 && cur != prev && cur != (prev + 1) % 4) begin
                abort_run("digit scan skipped a digit");
            end
            nib     = seg_digits_model[4*cur +: 4];
            exp_seg = {~seg_dp_model[cur], ~HEX_LIT[nib]};
            check_value("seg_o", data_t'(seg_o), data_t'(exp_seg));
            seen[cur] = 1'b1;
            prev      = cur;
        end
        if (seen != 4'hf) abort_run("not every digit was shown during the scan");
    endtask

    task automatic run_display_test();
        data_t dat;
        data_t rd;
        sel_t  sel;
        for (int r = 0; r < N_SEG; r++) begin
            dat = $urandom;
            sel = sel_t'($urandom_range(15));
            bus_write(SEG7_BASE, dat, sel, 1);
            seg_digits_model = lane_merge(seg_digits_model, dat, sel) & 32'h0000_ffff;
            dat = $urandom;
            bus_write(SEG7_BASE + 32'd1, dat, 4'hf, 1);
            seg_dp_model = dat & 32'h0000_000f;
            bus_read(SEG7_BASE, rd, 1);
            check_value("wb_dat_o", rd, seg_digits_model);
            bus_read(SEG7_BASE + 32'd1, rd, 1);
            check_value("wb_dat_o", rd, seg_dp_model);
            check_scan();
        end
    endtask

    task automatic run_default_test();
        addr_t adr;
        data_t rd;
        for (int n = 0; n < N_DFLT; n++) begin
            adr = pick_unmapped();
            bus_write(adr, $urandom, sel_t'($urandom_range(15)), 1); // must be dropped
            bus_read(pick_unmapped(), rd, 1);
            check_value("wb_dat_o", rd, DEFAULT_RDATA);
        end
    endtask

    task automatic recheck_all();
        data_t rd;
        foreach (written_q[i]) begin
            bus_read(RAM_BASE + addr_t'(written_q[i]), rd, 2);
            check_value("wb_dat_o", rd, ram_model[written_q[i]]);
        end
        bus_read(GPIO_BASE, rd, 1);
        check_value("wb_dat_o", rd, gpio_out_model);
        bus_read(GPIO_BASE + 32'd1, rd, 1);
        check_value("wb_dat_o", rd, gpio_dir_model);
        bus_read(SEG7_BASE, rd, 1);
        check_value("wb_dat_o", rd, seg_digits_model);
        bus_read(SEG7_BASE + 32'd1, rd, 1);
        check_value("wb_dat_o", rd, seg_dp_model);
    endtask

    initial begin
        void'($urandom(32'h28dd_eec1));
        reset_i          = 1'b1;
        wb_adr_i         = '0;
        wb_dat_i         = '0;
        wb_we_i          = 1'b0;
        wb_sel_i         = '0;
        wb_stb_i         = 1'b0;
        wb_cyc_i         = 1'b0;
        gpio_i           = '0;
        gpio_out_model   = '0;
        gpio_dir_model   = '0;
        seg_digits_model = '0;
        seg_dp_model     = '0;
        repeat (10) @(posedge clk);
        reset_i <= 1'b0;

        check_reset_state();
        run_ram_test();
        run_gpio_test();
        run_display_test();
        run_default_test();
        recheck_all(); // unmapped writes must not have touched any device
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- tenyr_devices.f
logic/tenyr_bus_pkg.sv
logic/wb_if.sv
logic/wb_decode.sv
logic/bus_ram.sv
logic/gpio_port.sv
logic/seg7_scan.sv
logic/tenyr_devices.sv
sim/tenyr_devices_asserts.sv
sim/tb_tenyr_devices.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and judges the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_tenyr_devices \
    -f tenyr_devices.f \
    -o tb_tenyr_devices

status=0
./obj_dir/tb_tenyr_devices > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "ERRORS FOUND" sim.log || ! grep -q "NO ERRORS" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
